/* list.f */
source/obj_pkg.sv
source/obj_mem.sv
source/obj_mem_arbiter.sv
source/obj_scanner.sv
source/obj_fetcher.sv
source/obj_row_buffer.sv
source/obj_row_double_buffer.sv
source/obj_engine_top.sv
testbench/tb_obj_engine.sv

/* Makefile */
TOOL    = verilator
FLAGS   = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP     = tb_obj_engine
FLIST   = list.f
OUTDIR  = obj_dir
BIN     = $(OUTDIR)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OUTDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf $(OUTDIR) $(LOG)

/* testbench/tb_obj_engine.sv */
`default_nettype none

module tb_obj_engine;
    timeunit 1ns;
    timeprecision 1ps;
    import obj_pkg::*;

    localparam int OBJ_COUNT   = 16;
    localparam int MAX_PER_ROW = 8;
    localparam int MEM_WORDS   = 4160;
    localparam int ROW_STARTS  = 25;
    // Render time plus a full readback per row, the memory fill, and slack.
    localparam int CYCLE_LIMIT = MEM_WORDS * 2
        + ROW_STARTS * (OBJ_COUNT * 8 + MAX_PER_ROW * 20 + 320) + 5000;

    logic              clock;
    logic              rst_n;
    logic              wr_strobe;
    logic [ADDR_W-1:0] wr_addr;
    logic [15:0]       wr_data;
    logic              row_start;
    logic [7:0]        row;
    logic [7:0]        rcol;
    obj_pixel_t        rdata;
    logic              busy;
    logic              row_done;

    logic [15:0] img [MEM_WORDS];
    obj_pixel_t  model_q [ROW_WIDTH];
    obj_pixel_t  exp_line [ROW_WIDTH];
    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          test_err0 = 0;
    int          starts = 0;
    int          done_count = 0;
    int          pulse_faults = 0;
    int          cycles = 0;
    logic        busy_prev = 1'b0;
    logic        done_prev = 1'b0;

    obj_engine_top #(
        .OBJ_COUNT(OBJ_COUNT),
        .MAX_PER_ROW(MAX_PER_ROW),
        .MEM_WORDS(MEM_WORDS)
    ) dut_i (
        .clock, .rst_n, .wr_strobe, .wr_addr, .wr_data,
        .row_start, .row, .rcol, .rdata, .busy, .row_done
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // row_done must be one cycle long and land on the edge where busy falls.
    always @(negedge clock) begin
        if (rst_n && row_done) begin
            done_count++;
            if (busy || !busy_prev || done_prev) begin
                pulse_faults++;
                $display("row_done at %0t did not line up with busy falling", $time);
            end
        end
        busy_prev = busy;
        done_prev = row_done;
    end

    function automatic logic [15:0] rand16();
        return 16'($random(seed));
    endfunction

    function automatic int rand_below(input int unsigned n);
        int unsigned v;
        v = $unsigned($random(seed));
        return int'(v % n);
    endfunction

    task automatic check_pixel(input string name, input obj_pixel_t exp, input obj_pixel_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_err0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [15:0] data);
        @(posedge clock);
        wr_strobe <= 1'b1;
        wr_addr   <= addr;
        wr_data   <= data;
        img[addr] = data;
    endtask

    task automatic end_writes();
        @(posedge clock);
        wr_strobe <= 1'b0;
    endtask

    task automatic write_oam(input int n, input logic [7:0] y, input logic [7:0] x,
                             input logic [5:0] tile, input logic [2:0] pal, input logic prio,
                             input logic pm, input logic hide);
        write_word(ADDR_W'(2 * n), {y, x});
        write_word(ADDR_W'(2 * n + 1), {4'h0, hide, pm, prio, pal, tile});
    endtask

    task automatic random_oam(input int base, input int tiles);
        for (int n = 0; n < OBJ_COUNT; n++) begin
            write_oam(n, 8'(base - 4 + rand_below(16)), 8'(rand_below(256)),
                      6'(rand_below(tiles)), 3'(rand_below(8)), rand_below(2) == 1,
                      rand_below(2) == 1, rand_below(8) == 0);
        end
        end_writes();
    endtask

    // Reference line: scan in OAM order, stop at the hit limit, merge per column.
    task automatic model_line(input logic [7:0] r);
        logic [15:0]       w0;
        logic [15:0]       w1;
        logic [7:0]        diff;
        logic [ADDR_W-1:0] addr;
        obj_pixel_t        cur;
        obj_pixel_t        nv;
        logic              open;
        int                hits;
        int                col;
        hits = 0;
        for (int c = 0; c < ROW_WIDTH; c++)
            model_q[8'(c)] = '0;
        for (int n = 0; n < OBJ_COUNT && hits < MAX_PER_ROW; n++) begin
            w0   = img[ADDR_W'(2 * n)];
            w1   = img[ADDR_W'(2 * n + 1)];
            diff = r - w0[15:8];
            if (diff < 8'd8) begin
                hits++;
                for (int i = 0; i < 8; i++) begin
                    col = int'(w0[7:0]) + i;
                    if (col < ROW_WIDTH) begin
                        addr = ADDR_W'(TILE_BASE + int'(w1[5:0]) * 64 + int'(diff) * 8 + i);
                        cur  = model_q[8'(col)];
                        if (w1[10])
                            open = (cur.color[3:0] == 4'h0);
                        else
                            open = !cur.color[15];
                        if (open) begin
                            nv = '0;
                            if (!w1[11]) begin
                                nv.prio    = w1[9];
                                nv.palette = w1[8:6];
                                nv.color   = img[addr];
                            end
                            nv.color[14] = nv.color[14] | cur.color[14];
                            model_q[8'(col)] = nv;
                        end
                    end
                end
            end
        end
    endtask

    task automatic start_row(input logic [7:0] r);
        @(posedge clock);
        row_start <= 1'b1;
        row       <= r;
        @(posedge clock);
        row_start <= 1'b0;
        starts++;
        @(negedge clock);
        check_flag("busy after row_start", 1'b1, busy);
    endtask

    task automatic read_line(input string name, input int r);
        obj_pixel_t expv;
        for (int c = 0; c < 256; c++) begin
            @(posedge clock);
            rcol <= 8'(c);
            @(negedge clock);
            expv = (c < ROW_WIDTH) ? exp_line[8'(c)] : '0;
            check_pixel($sformatf("%s row %0d col %0d", name, r, c), expv, rdata);
        end
    endtask

    task automatic wait_done();
        while (done_count < starts)
            @(posedge clock);
        repeat (2) @(posedge clock);
        check_count("row_done pulses", starts, done_count);
        check_count("row_done timing faults", 0, pulse_faults);
    endtask

    // Renders count rows plus one more, whose row_start exposes the last row.
    task automatic run_rows(input string name, input int first, input int count, input int noise);
        logic [7:0] r;
        for (int k = 0; k <= count; k++) begin
            r = 8'(first + k);
            model_line(r);
            start_row(r);
            for (int j = 0; j < noise; j++)
                write_word(ADDR_W'(TILE_BASE + 48 * 64 + rand_below(1024)), rand16());
            if (noise > 0)
                end_writes();
            if (k > 0)
                read_line(name, int'(r) - 1);
            wait_done();
            for (int c = 0; c < ROW_WIDTH; c++)
                exp_line[8'(c)] = model_q[8'(c)];
        end
    endtask

    initial begin
        seed      = 32'hd68;
        rst_n     = 1'b0;
        wr_strobe = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        row_start = 1'b0;
        row       = '0;
        rcol      = '0;
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);

        check_flag("busy after reset", 1'b0, busy);
        check_flag("row_done after reset", 1'b0, row_done);
        for (int c = 0; c < ROW_WIDTH; c++)
            exp_line[8'(c)] = '0;
        read_line("reset", 0);
        end_test("reset");

        for (int a = 0; a < MEM_WORDS; a++)
            write_word(ADDR_W'(a), rand16());
        end_writes();

        random_oam(0, 64);
        run_rows("random rows", 0, 12, 0);
        end_test("random rows");

        // Hidden sprites over visible ones, and sprites running off the right edge.
        for (int n = 6; n < OBJ_COUNT; n++)
            write_oam(n, 8'd200, 8'(n * 9), 6'(n), 3'd1, 1'b0, 1'b0, 1'b0);
        write_oam(0, 8'd18, 8'd10, 6'd5, 3'd2, 1'b1, 1'b0, 1'b1);
        write_oam(1, 8'd18, 8'd8, 6'd6, 3'd3, 1'b0, 1'b1, 1'b0);
        write_oam(2, 8'd18, 8'd236, 6'd7, 3'd4, 1'b0, 1'b0, 1'b0);
        write_oam(3, 8'd18, 8'd252, 6'd8, 3'd5, 1'b1, 1'b1, 1'b0);
        write_oam(4, 8'd18, 8'd232, 6'd9, 3'd6, 1'b0, 1'b0, 1'b1);
        write_oam(5, 8'd19, 8'd100, 6'd10, 3'd7, 1'b1, 1'b0, 1'b0);
        end_writes();
        run_rows("hidden and edge", 20, 2, 0);
        end_test("hidden and edge");

        // Tile 11 is transparent in direct mode but carries the window flag.
        // Tile 12 is opaque and never carries the flag itself.
        for (int a = 0; a < 64; a++) begin
            write_word(ADDR_W'(TILE_BASE + 11 * 64 + a), 16'h4000 | (rand16() & 16'h3fff));
            write_word(ADDR_W'(TILE_BASE + 12 * 64 + a), 16'h8000 | (rand16() & 16'hbfff));
        end
        for (int n = 3; n < OBJ_COUNT; n++)
            write_oam(n, 8'd200, 8'(n * 9), 6'(n), 3'd1, 1'b0, 1'b0, 1'b0);
        write_oam(0, 8'd40, 8'd50, 6'd11, 3'd1, 1'b0, 1'b0, 1'b0);
        write_oam(1, 8'd40, 8'd54, 6'd12, 3'd2, 1'b1, 1'b0, 1'b0);
        write_oam(2, 8'd40, 8'd56, 6'd13, 3'd3, 1'b0, 1'b1, 1'b0);
        end_writes();
        run_rows("window flag", 40, 2, 0);
        end_test("window flag");

        for (int n = 0; n < OBJ_COUNT; n++) begin
            write_oam(n, 8'd60, 8'(n * 14), 6'(rand_below(64)), 3'(rand_below(8)),
                      rand_below(2) == 1, rand_below(2) == 1, 1'b0);
        end
        end_writes();
        run_rows("row overflow", 60, 1, 0);
        end_test("row overflow");

        // Tiles 48 and up stay unused so host writes there cannot change a line.
        random_oam(80, 48);
        run_rows("host writes", 80, 3, 40);
        end_test("host writes");

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/obj_engine_top.sv */
`default_nettype none

module obj_engine_top #(
    parameter int OBJ_COUNT   = 16,
    parameter int MAX_PER_ROW = 8,
    parameter int MEM_WORDS   = 4160
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       wr_strobe,
    input  logic [obj_pkg::ADDR_W-1:0] wr_addr,
    input  logic [15:0]                wr_data,
    input  logic                       row_start,
    input  logic [7:0]                 row,
    input  logic [7:0]                 rcol,
    output obj_pkg::obj_pixel_t        rdata,
    output logic                       busy,
    output logic                       row_done
);
    import obj_pkg::*;

    logic [7:0]  row_q;
    mem_req_t    host_req;
    mem_req_t    scan_req;
    mem_req_t    fetch_req;
    mem_req_t    mem_req;
    logic [15:0] mem_rdata;
    logic        scan_gnt;
    logic        fetch_gnt;
    logic        scan_rvalid;
    logic        fetch_rvalid;
    logic        entry_valid;
    obj_entry_t  entry;
    logic [2:0]  line;
    logic        fetch_ready;
    logic        scan_done;
    logic        buf_we;
    logic        buf_clear;
    logic        buf_transparent;
    logic        buf_palettemode;
    logic [7:0]  buf_wcol;
    obj_pixel_t  buf_wdata;

    // Row number stays fixed until the next row_start.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            row_q <= '0;
        else if (row_start)
            row_q <= row;
    end

    assign host_req = '{req: wr_strobe, we: wr_strobe, addr: wr_addr, wdata: wr_data};

    obj_mem #(.MEM_WORDS(MEM_WORDS)) mem_i (
        .clock, .rst_n, .req(mem_req), .rdata(mem_rdata)
    );

    obj_mem_arbiter arb_i (
        .clock, .rst_n, .host_req, .scan_req, .fetch_req,
        .scan_gnt, .fetch_gnt, .mem_req, .mem_rdata,
        .scan_rvalid, .fetch_rvalid
    );

    obj_scanner #(.OBJ_COUNT(OBJ_COUNT), .MAX_PER_ROW(MAX_PER_ROW)) scan_i (
        .clock, .rst_n, .row_start, .row(row_q),
        .mem_req(scan_req), .gnt(scan_gnt), .rvalid(scan_rvalid), .rdata(mem_rdata),
        .fetch_ready, .entry_valid, .entry, .line, .scan_done
    );

    obj_fetcher fetch_i (
        .clock, .rst_n, .row_start, .entry_valid, .entry, .line,
        .fetch_ready, .scan_done,
        .mem_req(fetch_req), .gnt(fetch_gnt), .rvalid(fetch_rvalid), .rdata(mem_rdata),
        .we(buf_we), .clear(buf_clear), .transparent(buf_transparent),
        .palettemode(buf_palettemode), .wcol(buf_wcol), .wdata(buf_wdata),
        .row_done, .busy
    );

    obj_row_double_buffer rowbuf_i (
        .clock, .rst_n, .row(row_q),
        .we(buf_we), .clear(buf_clear), .transparent(buf_transparent),
        .palettemode(buf_palettemode), .wcol(buf_wcol), .rcol,
        .wdata(buf_wdata), .rdata
    );

endmodule

`default_nettype wire

/* source/obj_row_double_buffer.sv */
`default_nettype none

module obj_row_double_buffer (
    input  logic                clock,
    input  logic                rst_n,
    input  logic [7:0]          row,
    input  logic                we,
    input  logic                clear,
    input  logic                transparent,
    input  logic                palettemode,
    input  logic [7:0]          wcol,
    input  logic [7:0]          rcol,
    input  obj_pkg::obj_pixel_t wdata,
    output obj_pkg::obj_pixel_t rdata
);
    import obj_pkg::*;

    obj_pixel_t rdata_even;
    obj_pixel_t rdata_odd;
    logic       odd;

    assign odd = row[0];

    obj_row_buffer even_buf_i (
        .clock, .rst_n,
        .en(we && !odd), .clear(clear && !odd),
        .transparent, .palettemode, .wcol, .rcol, .wdata,
        .rdata(rdata_even)
    );

    obj_row_buffer odd_buf_i (
        .clock, .rst_n,
        .en(we && odd), .clear(clear && odd),
        .transparent, .palettemode, .wcol, .rcol, .wdata,
        .rdata(rdata_odd)
    );

    // Display side sees the buffer finished on the previous row.
    assign rdata = odd ? rdata_even : rdata_odd;

endmodule

`default_nettype wire

/* source/obj_row_buffer.sv */
`default_nettype none

module obj_row_buffer (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                en,
    input  logic                clear,
    input  logic                transparent,
    input  logic                palettemode,
    input  logic [7:0]          wcol,
    input  logic [7:0]          rcol,
    input  obj_pkg::obj_pixel_t wdata,
    output obj_pkg::obj_pixel_t rdata
);
    import obj_pkg::*;

    obj_pixel_t pix_q [ROW_WIDTH];
    obj_pixel_t cur;
    obj_pixel_t merged;
    logic       wcol_ok;
    logic       wr_ok;

    assign wcol_ok = (wcol < 8'(ROW_WIDTH));

    // First opaque pixel in a column wins, the window flag is kept.
    always_comb begin
        cur    = wcol_ok ? pix_q[wcol] : '0;
        merged = transparent ? '0 : wdata;
        merged.color[14] = merged.color[14] | cur.color[14];
        wr_ok  = en && wcol_ok && pixel_is_transparent(cur.color, palettemode);
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ROW_WIDTH; i++) begin
                pix_q[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < ROW_WIDTH; i++) begin
                pix_q[i] <= '0;
            end
        end else if (wr_ok) begin
            pix_q[wcol] <= merged;
        end
    end

    assign rdata = (rcol < 8'(ROW_WIDTH)) ? pix_q[rcol] : '0;

endmodule

`default_nettype wire

/* source/obj_fetcher.sv */
`default_nettype none

module obj_fetcher (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                row_start,
    input  logic                entry_valid,
    input  obj_pkg::obj_entry_t entry,
    input  logic [2:0]          line,
    output logic                fetch_ready,
    input  logic                scan_done,
    output obj_pkg::mem_req_t   mem_req,
    input  logic                gnt,
    input  logic                rvalid,
    input  logic [15:0]         rdata,
    output logic                we,
    output logic                clear,
    output logic                transparent,
    output logic                palettemode,
    output logic [7:0]          wcol,
    output obj_pkg::obj_pixel_t wdata,
    output logic                row_done,
    output logic                busy
);
    import obj_pkg::*;

    fetch_state_t state;
    obj_entry_t   ent_q;
    logic [2:0]   line_q;
    logic [2:0]   pix;
    logic         pend;
    logic         done_seen;
    logic [15:0]  color_q;
    logic [8:0]   col;

    // A carry into bit 8 means the column wrapped and the pixel is dropped.
    assign col = {1'b0, ent_q.x} + {6'd0, pix};

    assign fetch_ready = (state == F_WAIT);
    assign clear       = (state == F_CLEAR);
    assign we          = (state == F_WRITE) && !col[8];
    assign wcol        = col[7:0];
    assign transparent = ent_q.hide;
    assign palettemode = ent_q.palettemode;
    assign wdata       = '{prio: ent_q.prio, palette: ent_q.palette, color: color_q};

    always_comb begin
        mem_req      = '0;
        mem_req.req  = (state == F_READ) && !pend;
        mem_req.addr = ADDR_W'(TILE_BASE) + ADDR_W'({ent_q.tile, line_q, pix});
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= F_IDLE;
            pix       <= '0;
            pend      <= 1'b0;
            done_seen <= 1'b0;
            busy      <= 1'b0;
            row_done  <= 1'b0;
        end else begin
            row_done <= 1'b0;
            if (gnt)
                pend <= 1'b1;
            else if (rvalid)
                pend <= 1'b0;
            if (scan_done)
                done_seen <= 1'b1;
            case (state)
                F_IDLE: begin
                    if (row_start) begin
                        done_seen <= 1'b0;
                        busy      <= 1'b1;
                        state     <= F_CLEAR;
                    end
                end
                F_CLEAR: state <= F_WAIT;
                F_WAIT: begin
                    if (entry_valid) begin
                        pix   <= '0;
                        state <= F_READ;
                    end else if (done_seen || scan_done) begin
                        busy     <= 1'b0;
                        row_done <= 1'b1;
                        state    <= F_IDLE;
                    end
                end
                F_READ: begin
                    if (rvalid)
                        state <= F_WRITE;
                end
                F_WRITE: begin
                    pix   <= pix + 1'b1;
                    state <= (pix == 3'd7) ? F_WAIT : F_READ;
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == F_WAIT && entry_valid) begin
            ent_q  <= entry;
            line_q <= line;
        end
        if (state == F_READ && rvalid)
            color_q <= rdata;
    end

    a_clear_we: assert property (@(posedge clock) disable iff (!rst_n)
        !(clear && we));

endmodule

`default_nettype wire

/* source/obj_scanner.sv */
`default_nettype none

module obj_scanner #(
    parameter int OBJ_COUNT   = 16,
    parameter int MAX_PER_ROW = 8
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                row_start,
    input  logic [7:0]          row,
    output obj_pkg::mem_req_t   mem_req,
    input  logic                gnt,
    input  logic                rvalid,
    input  logic [15:0]         rdata,
    input  logic                fetch_ready,
    output logic                entry_valid,
    output obj_pkg::obj_entry_t entry,
    output logic [2:0]          line,
    output logic                scan_done
);
    import obj_pkg::*;

    localparam int IDX_W = (OBJ_COUNT > 1) ? $clog2(OBJ_COUNT) : 1;
    localparam int HIT_W = $clog2(MAX_PER_ROW + 1);

    scan_state_t      state;
    logic [IDX_W-1:0] idx;
    logic [HIT_W-1:0] hits;
    logic             pend;
    logic [15:0]      word0;
    logic [7:0]       diff;
    logic             last;

    // Sprite line, valid as a hit when below 8.
    assign diff = row - word0[15:8];
    assign last = (idx == IDX_W'(OBJ_COUNT - 1));

    always_comb begin
        mem_req      = '0;
        mem_req.req  = (state == S_READ0 || state == S_READ1) && !pend;
        mem_req.addr = ADDR_W'({idx, state == S_READ1});
    end

    assign entry_valid = (state == S_HAND) && fetch_ready;
    assign scan_done   = (state == S_DONE);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            idx   <= '0;
            hits  <= '0;
            pend  <= 1'b0;
        end else begin
            if (gnt)
                pend <= 1'b1;
            else if (rvalid)
                pend <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (row_start) begin
                        idx   <= '0;
                        hits  <= '0;
                        state <= S_READ0;
                    end
                end
                S_READ0: begin
                    if (rvalid)
                        state <= S_READ1;
                end
                S_READ1: begin
                    if (rvalid) begin
                        if (diff[7:3] == 5'd0) begin
                            state <= S_HAND;
                        end else if (last) begin
                            state <= S_DONE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= S_READ0;
                        end
                    end
                end
                S_HAND: begin
                    if (fetch_ready) begin
                        hits <= hits + 1'b1;
                        if (last || hits == HIT_W'(MAX_PER_ROW - 1)) begin
                            state <= S_DONE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= S_READ0;
                        end
                    end
                end
                S_DONE:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_READ0 && rvalid)
            word0 <= rdata;
        if (state == S_READ1 && rvalid) begin
            entry <= {rdata, word0};
            line  <= diff[2:0];
        end
    end

    a_hit_limit: assert property (@(posedge clock) disable iff (!rst_n)
        hits <= HIT_W'(MAX_PER_ROW));

endmodule

`default_nettype wire

/* source/obj_mem_arbiter.sv */
`default_nettype none

module obj_mem_arbiter (
    input  logic              clock,
    input  logic              rst_n,
    input  obj_pkg::mem_req_t host_req,
    input  obj_pkg::mem_req_t scan_req,
    input  obj_pkg::mem_req_t fetch_req,
    output logic              scan_gnt,
    output logic              fetch_gnt,
    output obj_pkg::mem_req_t mem_req,
    input  logic [15:0]       mem_rdata,
    output logic              scan_rvalid,
    output logic              fetch_rvalid
);
    import obj_pkg::*;

    mem_src_t src;
    mem_src_t src_q;

    // Host strobes cannot wait, so they always win.
    always_comb begin
        if (host_req.req)
            src = SRC_HOST;
        else if (fetch_req.req)
            src = SRC_FETCH;
        else if (scan_req.req)
            src = SRC_SCAN;
        else
            src = SRC_NONE;
    end

    always_comb begin
        case (src)
            SRC_HOST:  mem_req = host_req;
            SRC_FETCH: mem_req = fetch_req;
            SRC_SCAN:  mem_req = scan_req;
            default:   mem_req = '0;
        endcase
    end

    assign scan_gnt  = (src == SRC_SCAN);
    assign fetch_gnt = (src == SRC_FETCH);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            src_q <= SRC_NONE;
        else
            src_q <= src;
    end

    assign scan_rvalid  = (src_q == SRC_SCAN);
    assign fetch_rvalid = (src_q == SRC_FETCH);

    a_one_owner: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0({host_req.req, scan_gnt, fetch_gnt}));

    // Read data handed back must come from a word that was written.
    a_rdata_known: assert property (@(posedge clock) disable iff (!rst_n)
        (scan_rvalid || fetch_rvalid) |-> !$isunknown(mem_rdata));

endmodule

`default_nettype wire

/* source/obj_mem.sv */
`default_nettype none

module obj_mem #(
    parameter int MEM_WORDS = 4160
) (
    input  logic              clock,
    input  logic              rst_n,
    input  obj_pkg::mem_req_t req,
    output logic [15:0]       rdata
);
    import obj_pkg::*;

    logic [15:0] mem [MEM_WORDS];
    logic        in_range;

    assign in_range = (req.addr < ADDR_W'(MEM_WORDS));

    always_ff @(posedge clock) begin
        if (req.req && req.we && in_range)
            mem[req.addr] <= req.wdata;
    end

    // One cycle read latency.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            rdata <= '0;
        else if (req.req && !req.we)
            rdata <= in_range ? mem[req.addr] : 16'h0;
    end

endmodule

`default_nettype wire

/* source/obj_pkg.sv */
`default_nettype none

package obj_pkg;

    localparam int ROW_WIDTH = 240;
    localparam int TILE_BASE = 64;
    localparam int ADDR_W    = 13;

    // Color bit 14 is the sticky window flag.
    typedef struct packed {
        logic        prio;
        logic [2:0]  palette;
        logic [15:0] color;
    } obj_pixel_t;

    // Upper half is OAM word 2n+1, lower half is OAM word 2n.
    typedef struct packed {
        logic [3:0] rsvd;
        logic       hide;
        logic       palettemode;
        logic       prio;
        logic [2:0] palette;
        logic [5:0] tile;
        logic [7:0] y;
        logic [7:0] x;
    } obj_entry_t;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [15:0]       wdata;
    } mem_req_t;

    typedef enum logic [1:0] {SRC_NONE, SRC_HOST, SRC_SCAN, SRC_FETCH} mem_src_t;

    typedef enum logic [2:0] {S_IDLE, S_READ0, S_READ1, S_HAND, S_DONE} scan_state_t;

    typedef enum logic [2:0] {F_IDLE, F_CLEAR, F_WAIT, F_READ, F_WRITE} fetch_state_t;

    function automatic logic pixel_is_transparent(input logic [15:0] color,
                                                  input logic        palettemode);
        if (palettemode)
            return color[3:0] == 4'h0;
        return !color[15];
    endfunction

endpackage

`default_nettype wire
